/* src/exe_params.svh */
`ifndef EXE_PARAMS_SVH
`define EXE_PARAMS_SVH

// Datapath width, also the pc width
`define EXE_XLEN 64

// Integer register file depth
`define EXE_NREG 32

// Bits needed to address one register
`define EXE_RIDX_W 5

`endif

/* src/exe_pkg.sv */
`include "exe_params.svh"

package exe_pkg;

	typedef logic [`EXE_XLEN-1:0]   xdata_t;	// Register value or pc
	typedef logic [`EXE_RIDX_W-1:0] ridx_t;	// Register index

	// Branch kinds seen by the bru, six conditional then the two jumps
	typedef enum logic [2:0] {
		BRU_EQ,	// Taken if src1 == src2
		BRU_NE,	// Taken if src1 != src2
		BRU_LT,	// Signed less than
		BRU_GE,	// Signed greater or equal
		BRU_LTU,	// Unsigned less than
		BRU_GEU,	// Unsigned greater or equal
		BRU_JAL,	// Direct jump, link only
		BRU_JALR	// Indirect jump, link and target
	} bru_op_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,	// Signed set-less-than
		ALU_SLTU	// Unsigned set-less-than
	} alu_op_t;

	// Writeback arbiter FSM
	typedef enum logic [1:0] {
		WB_IDLE,	// Free, write goes out here
		WB_ACK,	// Ack high, waiting for req to fall
		WB_DROP	// Ack low again, unit may re-arm
	} wb_state_t;

endpackage

/* src/wb_if.sv */
`timescale 1ns/1ns

// Four-phase writeback link between one unit and the arbiter
interface wb_if import exe_pkg::*; ();

	logic   req;	// Unit wants the write port
	logic   ack;	// Arbiter has written the value
	ridx_t  rd;	// Destination, stable while req
	xdata_t res;	// Value, stable while req

	modport unit (
		output req,
		output rd,
		output res,
		input  ack
	);

	modport arb (
		input  req,
		input  rd,
		input  res,
		output ack
	);

endinterface

/* src/reg_file.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module reg_file import exe_pkg::*; (
	input  logic   CLK,
	input  logic   rst_n,
	input  ridx_t  raddr0,	// bru rs1
	input  ridx_t  raddr1,	// bru rs2
	input  ridx_t  raddr2,	// alu rs1
	input  ridx_t  raddr3,	// alu rs2
	output xdata_t rdata0,
	output xdata_t rdata1,
	output xdata_t rdata2,
	output xdata_t rdata3,
	input  logic   we,	// From the writeback arbiter
	input  ridx_t  waddr,
	input  xdata_t wdata
);

	xdata_t regs [`EXE_NREG];	// x0 slot stays zero

	// x0 is forced to zero on every read port
	function automatic xdata_t rd_port(input ridx_t addr);
		return (addr == '0) ? '0 : regs[addr];
	endfunction

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXE_NREG; i++) begin
				regs[i] <= '0;	// Whole file starts at zero
			end
		end else if (we && (waddr != '0)) begin
			regs[waddr] <= wdata;	// Writes to x0 are dropped
		end
	end

	// Plain stored value, a same-cycle write is seen next cycle
	assign rdata0 = rd_port(raddr0);
	assign rdata1 = rd_port(raddr1);
	assign rdata2 = rd_port(raddr2);
	assign rdata3 = rd_port(raddr3);

endmodule

/* src/bru.sv */
`timescale 1ns/1ns

module bru import exe_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    flush,	// Kills redirect and link of new ops
	input  logic    valid,	// Op offered by issue
	output logic    ready,	// Low while a link is in flight
	input  bru_op_t op,
	input  logic    is_rvc,	// Compressed op, link is pc+2
	input  ridx_t   rd,
	input  xdata_t  pc,
	input  xdata_t  imm,
	input  xdata_t  src1,	// Register file value of rs1
	input  xdata_t  src2,	// Register file value of rs2
	output logic    taken,	// Last conditional outcome
	output logic    taken_valid,	// One-cycle strobe for taken
	output logic    jalr_valid,	// One-cycle strobe for jalr_pc
	output xdata_t  jalr_pc,
	wb_if.unit      wb
);

	logic   accept;	// Issue handshake fires
	logic   live;	// Accepted and not flushed
	logic   is_jump;
	logic   is_cond;
	logic   cond_hit;	// Comparison result for op
	logic   req_q;	// Link writeback pending
	xdata_t link_q;
	ridx_t  rd_q;
	xdata_t link_nxt;
	xdata_t jalr_nxt;

	assign accept  = valid & ready;
	assign live    = accept & ~flush;
	assign is_jump = (op == BRU_JAL) | (op == BRU_JALR);
	assign is_cond = ~is_jump;

	// Issue waits until the previous handshake is fully released
	assign ready = ~req_q & ~wb.ack;

	always_comb begin
		case (op)
			BRU_EQ:  cond_hit = (src1 == src2);
			BRU_NE:  cond_hit = (src1 != src2);
			BRU_LT:  cond_hit = ($signed(src1) < $signed(src2));
			BRU_GE:  cond_hit = ($signed(src1) >= $signed(src2));
			BRU_LTU: cond_hit = (src1 < src2);
			BRU_GEU: cond_hit = (src1 >= src2);
			default: cond_hit = 1'b0;	// Jumps never go through taken
		endcase
	end

	assign link_nxt = pc + (is_rvc ? xdata_t'(2) : xdata_t'(4));	// Return address
	assign jalr_nxt = (src1 + imm) & ~xdata_t'(1);	// LSB cleared per ISA

	// Redirect strobes to the pc generator
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			taken       <= 1'b0;
			taken_valid <= 1'b0;
			jalr_valid  <= 1'b0;
		end else begin
			taken_valid <= live & is_cond;
			jalr_valid  <= live & (op == BRU_JALR);
			if (live & is_cond) begin
				taken <= cond_hit;	// Otherwise hold old outcome
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (accept && (op == BRU_JALR)) begin
			jalr_pc <= jalr_nxt;	// Lines up with jalr_valid
		end
		if (accept & is_jump) begin
			link_q <= link_nxt;
			rd_q   <= rd;
		end
	end

	// Four-phase request, x0 destinations skip the write port
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else if (live & is_jump & (rd != '0)) begin
			req_q <= 1'b1;
		end else if (wb.ack) begin
			req_q <= 1'b0;	// Phase 3, arbiter has written
		end
	end

	assign wb.req = req_q;
	assign wb.rd  = rd_q;
	assign wb.res = link_q;

endmodule

/* src/alu.sv */
`timescale 1ns/1ns

module alu import exe_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    flush,	// Result of new ops is dropped
	input  logic    valid,
	output logic    ready,	// Low until writeback is released
	input  alu_op_t op,
	input  logic    use_imm,	// Second operand from imm
	input  ridx_t   rd,
	input  xdata_t  imm,
	input  xdata_t  src1,
	input  xdata_t  src2,
	wb_if.unit      wb
);

	logic   accept;
	logic   req_q;	// Result waiting for the write port
	xdata_t op2;	// Selected second operand
	xdata_t res_nxt;
	xdata_t res_q;
	ridx_t  rd_q;

	assign accept = valid & ready;
	assign ready  = ~req_q & ~wb.ack;	// Same release rule as bru
	assign op2    = use_imm ? imm : src2;

	always_comb begin
		case (op)
			ALU_ADD:  res_nxt = src1 + op2;
			ALU_SUB:  res_nxt = src1 - op2;
			ALU_AND:  res_nxt = src1 & op2;
			ALU_OR:   res_nxt = src1 | op2;
			ALU_XOR:  res_nxt = src1 ^ op2;
			ALU_SLT:  res_nxt = xdata_t'($signed(src1) < $signed(op2));
			ALU_SLTU: res_nxt = xdata_t'(src1 < op2);
			default:  res_nxt = '0;
		endcase
	end

	// Payload captured at issue, held through the handshake
	always_ff @(posedge CLK) begin
		if (accept) begin
			res_q <= res_nxt;
			rd_q  <= rd;
		end
	end

	// rd of x0 still requests, the file discards it
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			req_q <= 1'b0;
		end else if (accept & ~flush) begin
			req_q <= 1'b1;
		end else if (wb.ack) begin
			req_q <= 1'b0;
		end
	end

	assign wb.req = req_q;
	assign wb.rd  = rd_q;
	assign wb.res = res_q;

endmodule

/* src/wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter import exe_pkg::*; (
	input  logic   CLK,
	input  logic   rst_n,
	wb_if.arb      bru_wb,
	wb_if.arb      alu_wb,
	output logic   we,	// Register file write, one cycle per grant
	output ridx_t  waddr,
	output xdata_t wdata
);

	wb_state_t state;
	wb_state_t state_nxt;
	logic      any_req;
	logic      pick_alu;	// Choice made in WB_IDLE
	logic      grant_alu;	// Owner of current or last grant
	logic      owner_req;	// req of the unit being acked

	assign any_req = bru_wb.req | alu_wb.req;

	// Round robin only matters when both ask at once
	always_comb begin
		if (bru_wb.req & alu_wb.req) begin
			pick_alu = ~grant_alu;
		end else begin
			pick_alu = alu_wb.req;
		end
	end

	// Write happens in the grant cycle itself
	assign we    = (state == WB_IDLE) & any_req;
	assign waddr = pick_alu ? alu_wb.rd : bru_wb.rd;
	assign wdata = pick_alu ? alu_wb.res : bru_wb.res;

	assign bru_wb.ack = (state == WB_ACK) & ~grant_alu;
	assign alu_wb.ack = (state == WB_ACK) & grant_alu;
	assign owner_req  = grant_alu ? alu_wb.req : bru_wb.req;

	always_comb begin
		state_nxt = state;
		case (state)
			WB_IDLE: if (any_req) state_nxt = WB_ACK;
			WB_ACK:  if (!owner_req) state_nxt = WB_DROP;	// Phase 3 seen
			WB_DROP: state_nxt = WB_IDLE;	// Ack low for one cycle
			default: state_nxt = WB_IDLE;
		endcase
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state     <= WB_IDLE;
			grant_alu <= 1'b1;	// bru wins the first tie
		end else begin
			state <= state_nxt;
			if (we) begin
				grant_alu <= pick_alu;
			end
		end
	end

endmodule

/* src/exe_top.sv */
`timescale 1ns/1ns

module exe_top import exe_pkg::*; (
	input  logic    CLK,
	input  logic    rst_n,
	input  logic    flush,
	input  logic    bru_valid,
	output logic    bru_ready,
	input  bru_op_t bru_op,
	input  logic    bru_is_rvc,
	input  ridx_t   bru_rs1,
	input  ridx_t   bru_rs2,
	input  ridx_t   bru_rd,
	input  xdata_t  bru_pc,
	input  xdata_t  bru_imm,
	input  logic    alu_valid,
	output logic    alu_ready,
	input  alu_op_t alu_op,
	input  logic    alu_use_imm,
	input  ridx_t   alu_rs1,
	input  ridx_t   alu_rs2,
	input  ridx_t   alu_rd,
	input  xdata_t  alu_imm,
	output logic    taken,
	output logic    taken_valid,
	output logic    jalr_valid,
	output xdata_t  jalr_pc,
	output logic    wb_valid,	// Also the register file write enable
	output ridx_t   wb_rd,
	output xdata_t  wb_res
);

	xdata_t bru_src1;
	xdata_t bru_src2;
	xdata_t alu_src1;
	xdata_t alu_src2;

	wb_if bru_wb_if ();	// bru to arbiter link
	wb_if alu_wb_if ();	// alu to arbiter link

	reg_file u_reg_file (
		.CLK(CLK), .rst_n(rst_n),
		.raddr0(bru_rs1), .raddr1(bru_rs2), .raddr2(alu_rs1), .raddr3(alu_rs2),
		.rdata0(bru_src1), .rdata1(bru_src2), .rdata2(alu_src1), .rdata3(alu_src2),
		.we(wb_valid), .waddr(wb_rd), .wdata(wb_res)
	);

	bru u_bru (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .valid(bru_valid), .ready(bru_ready),
		.op(bru_op), .is_rvc(bru_is_rvc), .rd(bru_rd), .pc(bru_pc), .imm(bru_imm),
		.src1(bru_src1), .src2(bru_src2), .taken(taken), .taken_valid(taken_valid),
		.jalr_valid(jalr_valid), .jalr_pc(jalr_pc), .wb(bru_wb_if.unit)
	);

	alu u_alu (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .valid(alu_valid), .ready(alu_ready),
		.op(alu_op), .use_imm(alu_use_imm), .rd(alu_rd), .imm(alu_imm),
		.src1(alu_src1), .src2(alu_src2), .wb(alu_wb_if.unit)
	);

	wb_arbiter u_wb_arbiter (
		.CLK(CLK), .rst_n(rst_n), .bru_wb(bru_wb_if.arb), .alu_wb(alu_wb_if.arb),
		.we(wb_valid), .waddr(wb_rd), .wdata(wb_res)
	);

endmodule

/* tb/exe_asserts.sv */
`timescale 1ns/1ns

// Handshake rules on the arbiter side of both writeback links
module exe_asserts (
	input logic CLK,
	input logic rst_n,
	input logic bru_req,
	input logic bru_ack,
	input logic alu_req,
	input logic alu_ack,
	input logic we
);

	a_bru_ack_req: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(bru_ack) |-> bru_req) else $error("bru ack without request");
	a_alu_ack_req: assert property (@(posedge CLK) disable iff (!rst_n)
		$rose(alu_ack) |-> alu_req) else $error("alu ack without request");
	a_one_ack: assert property (@(posedge CLK) disable iff (!rst_n)
		!(bru_ack && alu_ack)) else $error("both acks high");
	a_bru_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		bru_req && !bru_ack |=> bru_req) else $error("bru req dropped before ack");
	a_alu_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		alu_req && !alu_ack |=> alu_req) else $error("alu req dropped before ack");
	a_we_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
		we |=> !we) else $error("write enable longer than one cycle");

endmodule

bind wb_arbiter exe_asserts u_exe_asserts (
	.CLK(CLK), .rst_n(rst_n), .bru_req(bru_wb.req), .bru_ack(bru_wb.ack),
	.alu_req(alu_wb.req), .alu_ack(alu_wb.ack), .we(we)
);

/* tb/exe_tb.sv */
`timescale 1ns/1ns
`include "exe_params.svh"

module exe_tb import exe_pkg::*; ();

	logic CLK;
	logic rst_n;
	logic flush;
	logic bru_valid;
	logic bru_ready;
	bru_op_t bru_op;
	logic bru_is_rvc;
	ridx_t bru_rs1;
	ridx_t bru_rs2;
	ridx_t bru_rd;
	xdata_t bru_pc;
	xdata_t bru_imm;
	logic alu_valid;
	logic alu_ready;
	alu_op_t alu_op;
	logic alu_use_imm;
	ridx_t alu_rs1;
	ridx_t alu_rs2;
	ridx_t alu_rd;
	xdata_t alu_imm;
	logic taken;
	logic taken_valid;
	logic jalr_valid;
	xdata_t jalr_pc;
	logic wb_valid;
	ridx_t wb_rd;
	xdata_t wb_res;

	xdata_t model [`EXE_NREG];	// Expected register file contents
	xdata_t lcg_state = 64'd34;
	string test_name = "reset";
	int errors = 0;
	int tests = 0;
	int strobes = 0;	// taken_valid plus jalr_valid pulses seen
	logic alu_pend = 0;	// alu result expected on the write port
	logic bru_pend = 0;	// bru link expected on the write port
	ridx_t alu_exp_rd;
	ridx_t bru_exp_rd;
	xdata_t alu_exp_res;
	xdata_t bru_exp_res;
	logic exp_taken = 0;
	xdata_t exp_jalr = '0;
	logic last_alu = 1;	// Unit of the previous write
	logic in_flush = 0;	// No strobe or write allowed
	logic wb_is_alu;
	logic wb_is_bru;

	exe_top u_exe_top (.*);

	initial begin
		CLK = 0;
		forever #2 CLK = ~CLK;	// 4 ns period
	end

	assign wb_is_alu = alu_pend && wb_rd == alu_exp_rd && wb_res == alu_exp_res;
	assign wb_is_bru = bru_pend && wb_rd == bru_exp_rd && wb_res == bru_exp_res;

	a_wb: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid |-> wb_is_alu || wb_is_bru)
	else begin
		$display("[FAIL] %s wb: expected x%0d=%h or x%0d=%h actual x%0d=%h", test_name,
			alu_exp_rd, alu_exp_res, bru_exp_rd, bru_exp_res,
			$sampled(wb_rd), $sampled(wb_res));
		errors++;
	end
	a_taken: assert property (@(posedge CLK) disable iff (!rst_n)
		taken_valid |-> taken == exp_taken)
	else begin
		$display("[FAIL] %s taken: expected %0b actual %0b", test_name, exp_taken,
			$sampled(taken));
		errors++;
	end
	a_jalr: assert property (@(posedge CLK) disable iff (!rst_n)
		jalr_valid |-> jalr_pc == exp_jalr)
	else begin
		$display("[FAIL] %s jalr_pc: expected %h actual %h", test_name, exp_jalr, $sampled(jalr_pc));
		errors++;
	end
	a_flush: assert property (@(posedge CLK) disable iff (!rst_n)
		in_flush |-> !(taken_valid || jalr_valid || wb_valid))
	else begin
		$display("%s: flushed operation produced a redirect or a writeback", test_name);
		errors++;
	end
	a_rr: assert property (@(posedge CLK) disable iff (!rst_n)
		wb_valid && alu_pend && bru_pend |-> wb_is_alu != last_alu)
	else begin
		$display("[FAIL] %s grant order: expected alu=%0b actual alu=%0b", test_name,
			!last_alu, $sampled(wb_is_alu));
		errors++;
	end
	a_stall: assert property (@(posedge CLK) disable iff (!rst_n)
		!(alu_pend && alu_ready) && !(bru_pend && bru_ready))
	else begin
		$display("%s: issue ready while a writeback is still pending", test_name);
		errors++;
	end

	// Model follows the write port, pre-edge values
	always @(posedge CLK) begin
		if (rst_n && (taken_valid || jalr_valid)) strobes++;
		if (rst_n && wb_valid) begin
			if (wb_is_alu) begin
				alu_pend = 0;
				last_alu = 1;
				if (alu_exp_rd != 0) model[alu_exp_rd] = alu_exp_res;	// x0 stays zero
			end else if (wb_is_bru) begin
				bru_pend = 0;
				last_alu = 0;
				if (bru_exp_rd != 0) model[bru_exp_rd] = bru_exp_res;
			end
		end
	end

	function automatic xdata_t lcg();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	function automatic xdata_t alu_model(input alu_op_t op, input xdata_t a, input xdata_t b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_AND: return a & b;
			ALU_OR:  return a | b;
			ALU_XOR: return a ^ b;
			ALU_SLT: return xdata_t'($signed(a) < $signed(b));
			default: return xdata_t'(a < b);	// Unsigned compare
		endcase
	endfunction

	function automatic logic cond_model(input bru_op_t op, input xdata_t a, input xdata_t b);
		case (op)
			BRU_EQ:  return a == b;
			BRU_NE:  return a != b;
			BRU_LT:  return $signed(a) < $signed(b);
			BRU_GE:  return $signed(a) >= $signed(b);
			BRU_LTU: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Called 1 ns after an edge, returns 1 ns after the accepting edge
	task automatic issue_alu(input alu_op_t op, input logic ui, input ridx_t rd,
			input ridx_t rs1, input ridx_t rs2, input xdata_t imm);
		int n;
		xdata_t res;
		n = 0;
		alu_valid = 1;
		alu_op = op;
		alu_use_imm = ui;
		alu_rd = rd;
		alu_rs1 = rs1;
		alu_rs2 = rs2;
		alu_imm = imm;
		while (!alu_ready && n < 100) begin
			@(posedge CLK);
			#1 n++;
		end
		if (!alu_ready) begin
			$display("%s: alu never became ready", test_name);
			errors++;
		end
		res = alu_model(op, model[rs1], ui ? imm : model[rs2]);
		@(posedge CLK);
		#1 alu_valid = 0;
		if (!flush) begin
			alu_exp_rd = rd;
			alu_exp_res = res;
			alu_pend = 1;
		end
	endtask

	task automatic issue_bru(input bru_op_t op, input logic rvc, input ridx_t rd,
			input ridx_t rs1, input ridx_t rs2, input xdata_t pc, input xdata_t imm);
		int n;
		int s0;
		n = 0;
		bru_valid = 1;
		bru_op = op;
		bru_is_rvc = rvc;
		bru_rd = rd;
		bru_rs1 = rs1;
		bru_rs2 = rs2;
		bru_pc = pc;
		bru_imm = imm;
		while (!bru_ready && n < 100) begin
			@(posedge CLK);
			#1 n++;
		end
		if (!bru_ready) begin
			$display("%s: bru never became ready", test_name);
			errors++;
		end
		if (op == BRU_JALR) exp_jalr = (model[rs1] + imm) & ~xdata_t'(1);
		else if (op != BRU_JAL) exp_taken = cond_model(op, model[rs1], model[rs2]);
		s0 = strobes;
		@(posedge CLK);
		#1 bru_valid = 0;
		// Link write lands together with the jalr strobe
		if (!flush && (op == BRU_JAL || op == BRU_JALR) && rd != 0) begin
			bru_exp_rd = rd;
			bru_exp_res = pc + (rvc ? 2 : 4);	// Link address
			bru_pend = 1;
		end
		if (!flush && op != BRU_JAL) begin
			n = 0;
			while (strobes == s0 && n < 20) begin	// Redirect strobe
				@(posedge CLK);
				#1 n++;
			end
			if (strobes == s0) begin
				$display("%s: no redirect strobe after a branch", test_name);
				errors++;
			end
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while ((alu_pend || bru_pend || !alu_ready || !bru_ready) && n < 100) begin
			@(posedge CLK);
			#1 n++;
		end
		if (alu_pend || bru_pend) begin
			$display("%s: timed out waiting for a writeback", test_name);
			errors++;
		end
	endtask

	task automatic end_test();
		tests++;
		$display("%s finished, %0d failures so far", test_name, errors);
	endtask

	initial begin
		flush = 0;
		bru_valid = 0;
		bru_op = BRU_EQ;
		bru_is_rvc = 0;
		bru_rs1 = '0;
		bru_rs2 = '0;
		bru_rd = '0;
		bru_pc = '0;
		bru_imm = '0;
		alu_valid = 0;
		alu_op = ALU_ADD;
		alu_use_imm = 0;
		alu_rs1 = '0;
		alu_rs2 = '0;
		alu_rd = '0;
		alu_imm = '0;
		for (int i = 0; i < `EXE_NREG; i++) model[i] = '0;
		rst_n = 0;
		repeat (16) @(posedge CLK);
		#1 rst_n = 1;

		test_name = "alu_results";
		for (int i = 1; i <= 8; i++) begin
			issue_alu(ALU_ADD, 1, ridx_t'(i), 0, 0, lcg());	// addi from x0
			wait_idle();
		end
		issue_alu(ALU_ADD, 1, 0, 1, 0, lcg());	// rd x0 is discarded
		wait_idle();
		issue_alu(ALU_OR, 0, 9, 0, 0, '0);	// x0 must still read zero
		wait_idle();
		for (int i = 0; i < 7; i++) begin
			issue_alu(alu_op_t'(3'(i)), 0, ridx_t'(16 + i), ridx_t'(1 + i), ridx_t'(2 + i), '0);
			wait_idle();
			issue_alu(alu_op_t'(3'(i)), 1, ridx_t'(23 + i), ridx_t'(8 - i), 0, lcg());
			wait_idle();
		end
		end_test();

		test_name = "cond_branches";
		issue_alu(ALU_ADD, 1, 10, 0, 0, 64'd5);
		issue_alu(ALU_ADD, 1, 11, 0, 0, 64'd5);
		issue_alu(ALU_ADD, 1, 12, 0, 0, -64'sd3);	// Negative, large unsigned
		issue_alu(ALU_ADD, 1, 13, 0, 0, 64'd7);
		wait_idle();
		for (int i = 0; i < 6; i++) begin
			issue_bru(bru_op_t'(3'(i)), 0, 0, 10, 11, lcg(), '0);
			issue_bru(bru_op_t'(3'(i)), 0, 0, 12, 13, lcg(), '0);
			issue_bru(bru_op_t'(3'(i)), 0, 0, 13, 12, lcg(), '0);
		end
		wait_idle();
		end_test();

		test_name = "jal_jalr";
		for (int rvc = 0; rvc < 2; rvc++) begin
			issue_bru(BRU_JAL, 1'(rvc), 14, 0, 0, lcg(), '0);
			wait_idle();
			issue_bru(BRU_JALR, 1'(rvc), 15, 1, 0, lcg(), lcg());
			wait_idle();
			issue_bru(BRU_JALR, 1'(rvc), 0, 12, 0, lcg(), 64'd9);	// No link for x0
			wait_idle();
		end
		end_test();

		test_name = "flush";
		in_flush = 1;
		flush = 1;
		issue_bru(BRU_EQ, 0, 0, 10, 11, lcg(), '0);
		issue_bru(BRU_JALR, 0, 5, 1, 0, lcg(), lcg());
		issue_alu(ALU_XOR, 0, 6, 1, 2, '0);
		flush = 0;
		repeat (10) @(posedge CLK);	// Nothing may come out
		#1 in_flush = 0;
		wait_idle();
		end_test();

		test_name = "shared_port";
		for (int i = 0; i < 6; i++) begin
			fork
				issue_alu(ALU_ADD, 1, 20, 1, 0, lcg());
				issue_bru(BRU_JAL, 1'(i), 21, 0, 0, lcg(), '0);
			join
		end
		wait_idle();
		end_test();

		$display("%0d tests run, %0d failures", tests, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/exe_pkg.sv
src/wb_if.sv
src/reg_file.sv
src/bru.sv
src/alu.sv
src/wb_arbiter.sv
src/exe_top.sv
tb/exe_asserts.sv
tb/exe_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the exe_top testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module exe_tb \
	-Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vexe_tb > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && exit 0 || exit 1
